/* design/cache_config.svh */
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// cache geometry, two ways of thirty-two sets
`define CACHE_WAYS 2
`define CACHE_SETS 32

// the byte address splits into tag, set index and line offset
`define TAG_BITS 10
`define SET_BITS 5
`define OFFSET_BITS 4

// one line is sixteen bytes
`define LINE_BYTES 16

// bus widths on the CPU and memory sides
`define CPU_DATA_BITS 32
`define MEM_DATA_BITS 16

// a line moves as eight memory beats
`define LINE_BEATS 8

`endif

/* design/cache_pkg.sv */
`default_nettype none

`include "cache_config.svh"

package cache_pkg;

    typedef logic [`TAG_BITS-1:0] tag_t;
    typedef logic [`SET_BITS-1:0] set_idx_t;
    typedef logic [`OFFSET_BITS-1:0] offset_t;
    typedef logic [`TAG_BITS+`SET_BITS-1:0] line_addr_t;
    typedef logic [`TAG_BITS+`SET_BITS+`OFFSET_BITS-1:0] cpu_addr_t;
    typedef logic [`CPU_DATA_BITS-1:0] cpu_word_t;
    typedef logic [`MEM_DATA_BITS-1:0] mem_beat_t;
    typedef logic [`LINE_BYTES*8-1:0] line_data_t;

    // CPU command codes, zero is left unused
    typedef enum logic [2:0] {
        read8 = 3'd1, read16 = 3'd2, read32 = 3'd3, invalidate = 3'd4,
        write8 = 3'd5, write16 = 3'd6, write32 = 3'd7
    } cpu_op_t;

    typedef enum logic [1:0] {
        nop = 2'd0, read_line = 2'd2, write_line = 2'd3
    } mem_cmd_t;

    typedef struct packed {
        cpu_op_t op;
        cpu_addr_t addr;
        cpu_word_t wdata;
    } cpu_request_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } line_meta_t;

    typedef enum logic [2:0] {
        idle, lookup, write_back, fill, access, invalidate_write_back
    } ctrl_state_t;

endpackage

`default_nettype wire

/* design/cpu_request_port.sv */
`default_nettype none

module cpu_request_port (
    input  logic                    dump_cache,
    input  logic                    reset,
    input  logic                    cmd_valid,
    input  cache_pkg::cpu_request_t cmd,
    input  logic                    done,
    output logic                    pending,
    output cache_pkg::cpu_request_t request
);
    import cache_pkg::*;

    // pending rises the cycle after an accepted strobe and falls after done
    always_ff @(posedge dump_cache) begin
        if (reset) begin
            pending <= 1'b0;
        end else if (done) begin
            pending <= 1'b0;
        end else if (cmd_valid) begin
            pending <= 1'b1;
        end
    end

    // a strobe that lands on a pending request is ignored
    always_ff @(posedge dump_cache) begin
        if (cmd_valid && !pending) begin
            request <= cmd;
        end
    end

    // the CPU waits for resp_valid before the next command
    assert property (@(posedge dump_cache) disable iff (reset)
        cmd_valid |-> !pending);

    // halfword accesses sit on even addresses
    assert property (@(posedge dump_cache) disable iff (reset)
        cmd_valid && (cmd.op inside {read16, write16}) |-> cmd.addr[0] == 1'b0);

    // word accesses sit on multiples of four
    assert property (@(posedge dump_cache) disable iff (reset)
        cmd_valid && (cmd.op inside {read32, write32}) |-> cmd.addr[1:0] == 2'b00);

endmodule

`default_nettype wire

/* design/cache_storage.sv */
`default_nettype none

`include "cache_config.svh"

module cache_storage (
    input  logic                  dump_cache,
    input  logic                  reset,
    input  cache_pkg::set_idx_t   set_idx,
    output cache_pkg::line_meta_t meta [`CACHE_WAYS],
    output cache_pkg::line_data_t lines [`CACHE_WAYS],
    output logic                  lru,
    input  logic                  meta_we,
    input  logic                  meta_way,
    input  cache_pkg::line_meta_t meta_in,
    input  logic                  data_we,
    input  logic [`LINE_BYTES-1:0] byte_en,
    input  cache_pkg::line_data_t data_in,
    input  logic                  fill_we,
    input  logic                  lru_we,
    input  logic                  lru_in
);
    import cache_pkg::*;

    line_meta_t meta_mem [`CACHE_SETS][`CACHE_WAYS];
    line_data_t data_mem [`CACHE_SETS][`CACHE_WAYS];
    // lru holds the most recently used way of each set
    logic [`CACHE_SETS-1:0] lru_bits;

    // reset empties every way, tags keep whatever they held
    always_ff @(posedge dump_cache) begin
        if (reset) begin
            for (int s = 0; s < `CACHE_SETS; s++) begin
                for (int w = 0; w < `CACHE_WAYS; w++) begin
                    meta_mem[s][w].valid <= 1'b0;
                    meta_mem[s][w].dirty <= 1'b0;
                end
            end
        end else if (meta_we) begin
            meta_mem[set_idx][meta_way] <= meta_in;
        end
    end

    // a fill replaces the line, a CPU write merges only enabled bytes
    always_ff @(posedge dump_cache) begin
        if (fill_we) begin
            data_mem[set_idx][meta_way] <= data_in;
        end else if (data_we) begin
            for (int b = 0; b < `LINE_BYTES; b++) begin
                if (byte_en[b]) begin
                    data_mem[set_idx][meta_way][b*8 +: 8] <= data_in[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge dump_cache) begin
        if (reset) begin
            lru_bits <= '0;
        end else if (lru_we) begin
            lru_bits[set_idx] <= lru_in;
        end
    end

    // both ways of the addressed set are read without a clock
    always_comb begin
        for (int w = 0; w < `CACHE_WAYS; w++) begin
            meta[w] = meta_mem[set_idx][w];
            lines[w] = data_mem[set_idx][w];
        end
    end

    assign lru = lru_bits[set_idx];

endmodule

`default_nettype wire

/* design/cache_controller.sv */
`default_nettype none

`include "cache_config.svh"

module cache_controller (
    input  logic                   dump_cache,
    input  logic                   reset,
    input  logic                   pending,
    input  cache_pkg::cpu_request_t request,
    output logic                   done,
    output cache_pkg::cpu_word_t   rdata,
    output cache_pkg::set_idx_t    set_idx,
    input  cache_pkg::line_meta_t  meta [`CACHE_WAYS],
    input  cache_pkg::line_data_t  lines [`CACHE_WAYS],
    input  logic                   lru,
    output logic                   meta_we,
    output logic                   meta_way,
    output cache_pkg::line_meta_t  meta_in,
    output logic                   data_we,
    output logic [`LINE_BYTES-1:0] byte_en,
    output cache_pkg::line_data_t  data_in,
    output logic                   fill_we,
    output logic                   lru_we,
    output logic                   lru_in,
    output logic                   mem_start,
    output cache_pkg::mem_cmd_t    mem_op,
    output cache_pkg::line_addr_t  mem_line_addr,
    output cache_pkg::line_data_t  mem_line,
    input  logic                   mem_finished,
    input  cache_pkg::line_data_t  fill_line
);
    import cache_pkg::*;

    ctrl_state_t state, next_state;
    tag_t req_tag;
    set_idx_t req_set;
    offset_t req_off;
    logic hit0, hit1, hit, victim, way_q, cur_way, access_now;
    logic is_read, is_write, is_inval;
    logic [`LINE_BYTES-1:0] size_mask;
    line_meta_t cur_meta;
    line_data_t shifted;
    cpu_word_t word_mask;

    assign {req_tag, req_set, req_off} = request.addr;
    assign set_idx = req_set;
    assign hit0 = meta[0].valid && (meta[0].tag == req_tag);
    assign hit1 = meta[1].valid && (meta[1].tag == req_tag);
    assign hit = hit0 || hit1;
    // lru names the recently used way, so the other one is replaced
    assign victim = ~lru;
    assign cur_way = (state == lookup) ? (hit ? hit1 : victim) : way_q;
    assign cur_meta = meta[cur_way];
    assign is_read = request.op inside {read8, read16, read32};
    assign is_write = request.op inside {write8, write16, write32};
    assign is_inval = (request.op == invalidate);

    always_comb begin
        case (request.op)
            read8, write8: size_mask = `LINE_BYTES'(4'h1);
            read16, write16: size_mask = `LINE_BYTES'(4'h3);
            read32, write32: size_mask = `LINE_BYTES'(4'hf);
            default: size_mask = '0;
        endcase
    end

    assign byte_en = size_mask << req_off;
    assign data_in = (state == fill) ? fill_line
                                     : line_data_t'(request.wdata) << {req_off, 3'b000};
    assign mem_line = lines[cur_way];

    // the addressed bytes are moved down to bit zero and the rest cleared
    assign shifted = lines[cur_way] >> {req_off, 3'b000};
    assign word_mask = {{8{size_mask[3]}}, {8{size_mask[2]}}, {8{size_mask[1]}}, {8{size_mask[0]}}};
    assign rdata = (done && is_read) ? (shifted[`CPU_DATA_BITS-1:0] & word_mask) : '0;

    assign access_now = (state == access) || (state == lookup && hit && !is_inval);

    always_comb begin
        next_state = state;
        done = 1'b0;
        meta_we = 1'b0;
        meta_way = cur_way;
        meta_in = '{valid: 1'b1, dirty: 1'b0, tag: req_tag};
        data_we = 1'b0;
        fill_we = 1'b0;
        lru_we = 1'b0;
        lru_in = cur_way;
        mem_start = 1'b0;
        mem_op = nop;
        mem_line_addr = {req_tag, req_set};
        case (state)
            idle: begin
                if (pending) begin
                    next_state = lookup;
                end
            end
            lookup: begin
                if (is_inval) begin
                    if (!hit) begin
                        done = 1'b1;
                        next_state = idle;
                    end else if (cur_meta.dirty) begin
                        mem_start = 1'b1;
                        mem_op = write_line;
                        next_state = invalidate_write_back;
                    end else begin
                        meta_we = 1'b1;
                        meta_in = '{valid: 1'b0, dirty: 1'b0, tag: req_tag};
                        lru_we = 1'b1;
                        lru_in = ~cur_way;
                        done = 1'b1;
                        next_state = idle;
                    end
                end else if (hit) begin
                    next_state = idle;
                end else if (cur_meta.valid && cur_meta.dirty) begin
                    mem_start = 1'b1;
                    mem_op = write_line;
                    mem_line_addr = {cur_meta.tag, req_set};
                    next_state = write_back;
                end else begin
                    mem_start = 1'b1;
                    mem_op = read_line;
                    next_state = fill;
                end
            end
            write_back: begin
                if (mem_finished) begin
                    mem_start = 1'b1;
                    mem_op = read_line;
                    next_state = fill;
                end
            end
            fill: begin
                // the new line goes in clean and the access follows next cycle
                if (mem_finished) begin
                    fill_we = 1'b1;
                    meta_we = 1'b1;
                    next_state = access;
                end
            end
            access: begin
                next_state = idle;
            end
            invalidate_write_back: begin
                if (mem_finished) begin
                    meta_we = 1'b1;
                    meta_in = '{valid: 1'b0, dirty: 1'b0, tag: req_tag};
                    lru_we = 1'b1;
                    lru_in = ~way_q;
                    done = 1'b1;
                    next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
        if (access_now) begin
            done = 1'b1;
            lru_we = 1'b1;
            if (is_write) begin
                data_we = 1'b1;
                meta_we = 1'b1;
                meta_in = '{valid: 1'b1, dirty: 1'b1, tag: req_tag};
            end
        end
    end

    always_ff @(posedge dump_cache) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // the way chosen at lookup stays in use until the request ends
    always_ff @(posedge dump_cache) begin
        if (state == lookup) begin
            way_q <= cur_way;
        end
    end

    // every response answers a request held by the CPU port
    assert property (@(posedge dump_cache) disable iff (reset) done |-> pending);

endmodule

`default_nettype wire

/* design/memory_line_port.sv */
`default_nettype none

`include "cache_config.svh"

module memory_line_port (
    input  logic                  dump_cache,
    input  logic                  reset,
    input  logic                  mem_start,
    input  cache_pkg::mem_cmd_t   mem_op,
    input  cache_pkg::line_addr_t mem_line_addr,
    input  cache_pkg::line_data_t mem_line,
    output logic                  mem_finished,
    output cache_pkg::line_data_t fill_line,
    output cache_pkg::mem_cmd_t   mem_cmd,
    output cache_pkg::line_addr_t mem_addr,
    output cache_pkg::mem_beat_t  mem_wdata,
    input  logic                  mem_resp,
    input  cache_pkg::mem_beat_t  mem_rdata
);
    import cache_pkg::*;

    localparam int beat_w = $clog2(`LINE_BEATS);
    localparam logic [beat_w-1:0] last_beat = beat_w'(`LINE_BEATS - 1);

    mem_cmd_t cur_op;
    line_data_t line_q;
    logic [beat_w-1:0] beat_q;
    // sending covers the write beats, waiting lasts until the memory has answered
    logic sending, waiting;
    logic fill_beat;

    assign fill_beat = waiting && !sending && mem_resp && (cur_op == read_line);
    assign mem_wdata = sending ? line_q[beat_q*`MEM_DATA_BITS +: `MEM_DATA_BITS] : '0;

    always_ff @(posedge dump_cache) begin
        if (reset) begin
            mem_cmd <= nop;
            cur_op <= nop;
            beat_q <= '0;
            sending <= 1'b0;
            waiting <= 1'b0;
            mem_finished <= 1'b0;
        end else begin
            mem_cmd <= nop;
            mem_finished <= 1'b0;
            if (mem_start) begin
                mem_cmd <= mem_op;
                cur_op <= mem_op;
                beat_q <= '0;
                sending <= (mem_op == write_line);
                waiting <= (mem_op != nop);
            end else if (sending) begin
                beat_q <= beat_q + 1'b1;
                if (beat_q == last_beat) begin
                    sending <= 1'b0;
                end
            end else if (fill_beat) begin
                beat_q <= beat_q + 1'b1;
                if (beat_q == last_beat) begin
                    waiting <= 1'b0;
                    mem_finished <= 1'b1;
                end
            end else if (waiting && mem_resp) begin
                // a single pulse acknowledges the whole written line
                waiting <= 1'b0;
                mem_finished <= 1'b1;
            end
        end
    end

    always_ff @(posedge dump_cache) begin
        if (mem_start) begin
            line_q <= mem_line;
            mem_addr <= mem_line_addr;
        end
        if (fill_beat) begin
            fill_line[beat_q*`MEM_DATA_BITS +: `MEM_DATA_BITS] <= mem_rdata;
        end
    end

    // the memory only answers a command that is outstanding and fully sent
    assert property (@(posedge dump_cache) disable iff (reset)
        mem_resp |-> waiting && !sending);

endmodule

`default_nettype wire

/* design/cache_top.sv */
`default_nettype none

`include "cache_config.svh"

module cache_top (
    input  logic                    dump_cache,
    input  logic                    reset,
    input  logic                    cmd_valid,
    input  cache_pkg::cpu_request_t cmd,
    output logic                    resp_valid,
    output cache_pkg::cpu_word_t    rdata,
    output cache_pkg::mem_cmd_t     mem_cmd,
    output cache_pkg::line_addr_t   mem_addr,
    output cache_pkg::mem_beat_t    mem_wdata,
    input  logic                    mem_resp,
    input  cache_pkg::mem_beat_t    mem_rdata
);
    import cache_pkg::*;

    logic pending, lru, meta_we, meta_way, data_we, fill_we, lru_we, lru_in;
    logic mem_start, mem_finished;
    logic [`LINE_BYTES-1:0] byte_en;
    cpu_request_t request;
    set_idx_t set_idx;
    line_meta_t meta [`CACHE_WAYS];
    line_meta_t meta_in;
    line_data_t lines [`CACHE_WAYS];
    line_data_t data_in, mem_line, fill_line;
    mem_cmd_t mem_op;
    line_addr_t mem_line_addr;

    cpu_request_port cpu_request_port_inst (
        .dump_cache(dump_cache), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd),
        .done(resp_valid), .pending(pending), .request(request)
    );

    cache_controller cache_controller_inst (
        .dump_cache(dump_cache), .reset(reset), .pending(pending), .request(request),
        .done(resp_valid), .rdata(rdata), .set_idx(set_idx), .meta(meta), .lines(lines),
        .lru(lru), .meta_we(meta_we), .meta_way(meta_way), .meta_in(meta_in),
        .data_we(data_we), .byte_en(byte_en), .data_in(data_in), .fill_we(fill_we),
        .lru_we(lru_we), .lru_in(lru_in), .mem_start(mem_start), .mem_op(mem_op),
        .mem_line_addr(mem_line_addr), .mem_line(mem_line), .mem_finished(mem_finished),
        .fill_line(fill_line)
    );

    cache_storage cache_storage_inst (
        .dump_cache(dump_cache), .reset(reset), .set_idx(set_idx), .meta(meta),
        .lines(lines), .lru(lru), .meta_we(meta_we), .meta_way(meta_way),
        .meta_in(meta_in), .data_we(data_we), .byte_en(byte_en), .data_in(data_in),
        .fill_we(fill_we), .lru_we(lru_we), .lru_in(lru_in)
    );

    memory_line_port memory_line_port_inst (
        .dump_cache(dump_cache), .reset(reset), .mem_start(mem_start), .mem_op(mem_op),
        .mem_line_addr(mem_line_addr), .mem_line(mem_line), .mem_finished(mem_finished),
        .fill_line(fill_line), .mem_cmd(mem_cmd), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_resp(mem_resp), .mem_rdata(mem_rdata)
    );

endmodule

`default_nettype wire

/* dv/cache_checker.sv */
`default_nettype none

`include "cache_config.svh"

module cache_checker (
    input  logic                    dump_cache,
    input  logic                    reset,
    input  logic                    cmd_valid,
    input  cache_pkg::cpu_request_t cmd,
    input  logic                    resp_valid,
    input  cache_pkg::cpu_word_t    rdata,
    input  cache_pkg::mem_cmd_t     mem_cmd,
    input  cache_pkg::line_addr_t   mem_addr,
    input  logic                    mem_resp,
    input  cache_pkg::cpu_word_t    exp_rdata,
    input  logic [3:0]              exp_reads,
    input  logic [3:0]              exp_writes,
    output int                      error_count,
    output int                      check_count
);
    import cache_pkg::*;

    localparam int resp_limit = 200;

    int errors = 0;
    int checks = 0;
    logic just_reset, req_open, write_open, read_open;
    int reads_seen, writes_seen, cycles, write_beats_left, fill_beats_seen;
    line_addr_t req_line;

    assign error_count = errors;
    assign check_count = checks;

    task automatic compare_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected 0x%h got 0x%h at time %0t", name, expected, actual,
                     $time);
        end
    endtask

    task automatic report_problem(string what);
        errors++;
        $display("error at time %0t: %s", $time, what);
    endtask

    always @(posedge dump_cache) begin
        if (reset) begin
            just_reset = 1'b1;
            req_open = 1'b0;
            write_open = 1'b0;
            read_open = 1'b0;
            cycles = 0;
        end else begin
            // the first cycle out of reset must be quiet on both sides
            if (just_reset) begin
                compare_value("resp_valid", 32'd0, 32'(resp_valid));
                compare_value("mem_cmd", 32'(nop), 32'(mem_cmd));
                just_reset = 1'b0;
            end
            cycles++;
            if (cmd_valid) begin
                req_open = 1'b1;
                reads_seen = 0;
                writes_seen = 0;
                cycles = 0;
                req_line = line_addr_t'(cmd.addr >> `OFFSET_BITS);
            end
            if (mem_resp) begin
                if (write_open && write_beats_left > 0) begin
                    report_problem("memory answered a write_line before its last beat");
                end else if (write_open) begin
                    write_open = 1'b0;
                end else if (read_open) begin
                    fill_beats_seen++;
                    if (fill_beats_seen == `LINE_BEATS) begin
                        read_open = 1'b0;
                    end
                end else begin
                    report_problem("memory answered with no command outstanding");
                end
            end
            // beats 1 to 7 follow the command cycle of a write_line
            if (write_open && write_beats_left > 0) begin
                write_beats_left--;
            end
            case (mem_cmd)
                write_line: begin
                    writes_seen++;
                    write_open = 1'b1;
                    write_beats_left = `LINE_BEATS - 1;
                end
                read_line: begin
                    reads_seen++;
                    read_open = 1'b1;
                    fill_beats_seen = 0;
                    compare_value("mem_addr", 32'(req_line), 32'(mem_addr));
                end
                default: begin
                end
            endcase
            if ((mem_cmd != nop) && !req_open) begin
                report_problem("memory command issued with no CPU request pending");
            end
            if (resp_valid) begin
                if (!req_open) begin
                    report_problem("resp_valid pulsed with no request pending");
                end else begin
                    compare_value("rdata", exp_rdata, rdata);
                    compare_value("read_line count", 32'(exp_reads), 32'(reads_seen));
                    compare_value("write_line count", 32'(exp_writes), 32'(writes_seen));
                    // hits and absent invalidates answer two cycles after the strobe
                    if (exp_reads == 4'd0 && exp_writes == 4'd0) begin
                        compare_value("resp_valid latency", 32'd2, 32'(cycles));
                    end
                end
                req_open = 1'b0;
            end
            if (req_open && cycles == resp_limit) begin
                report_problem("no resp_valid within the response limit");
            end
        end
    end

endmodule

`default_nettype wire

/* dv/cache_tb.sv */
`default_nettype none

`include "cache_config.svh"

module cache_tb;
    import cache_pkg::*;

    localparam int resp_timeout = 250;

    // three tags of set 3, plus lines in set 7
    localparam cpu_addr_t t0_base = 19'h02430;
    localparam cpu_addr_t t1_base = 19'h0aa30;
    localparam cpu_addr_t t2_base = 19'h54630;
    localparam cpu_addr_t s7_base = 19'h3fe70;
    localparam cpu_addr_t s7_other = 19'h10070;

    typedef struct packed {
        cpu_op_t op;
        cpu_addr_t addr;
        cpu_word_t wdata;
        cpu_word_t rdata;
        logic [3:0] reads;
        logic [3:0] writes;
    } stim_entry_t;

    typedef enum logic [1:0] {mem_idle, mem_collect, mem_delay, mem_stream} mem_phase_t;

    logic dump_cache = 1'b0;
    logic reset = 1'b1;
    logic cmd_valid = 1'b0;
    cpu_request_t cmd = '0;
    logic resp_valid;
    cpu_word_t rdata;
    mem_cmd_t mem_cmd;
    line_addr_t mem_addr;
    mem_beat_t mem_wdata;
    logic mem_resp = 1'b0;
    mem_beat_t mem_rdata = '0;
    cpu_word_t exp_rdata = '0;
    logic [3:0] exp_reads = '0;
    logic [3:0] exp_writes = '0;
    int error_count, check_count;
    int timeouts = 0;

    stim_entry_t stimulus [$];
    logic [7:0] written_bytes [cpu_addr_t];
    logic [31:0] lfsr_state = 32'h3d32;
    mem_phase_t mem_phase = mem_idle;
    line_addr_t mem_line_q;
    logic mem_is_read;
    int beat_count, delay_count;

    always #10 dump_cache = ~dump_cache;

    cache_top cache_top_inst (
        .dump_cache(dump_cache), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd),
        .resp_valid(resp_valid), .rdata(rdata), .mem_cmd(mem_cmd), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_resp(mem_resp), .mem_rdata(mem_rdata)
    );

    cache_checker response_watch (
        .dump_cache(dump_cache), .reset(reset), .cmd_valid(cmd_valid), .cmd(cmd),
        .resp_valid(resp_valid), .rdata(rdata), .mem_cmd(mem_cmd), .mem_addr(mem_addr),
        .mem_resp(mem_resp), .exp_rdata(exp_rdata), .exp_reads(exp_reads),
        .exp_writes(exp_writes), .error_count(error_count), .check_count(check_count)
    );

    // memory starts as the low address byte XOR the next byte, top bits folded in
    function automatic logic [7:0] pattern_byte(cpu_addr_t a);
        return a[7:0] ^ a[15:8] ^ {5'b00000, a[18:16]};
    endfunction

    function automatic cpu_word_t pattern_value(cpu_addr_t addr, int nbytes);
        cpu_word_t v;
        v = '0;
        for (int i = 0; i < nbytes; i++) begin
            v[i*8 +: 8] = pattern_byte(addr + cpu_addr_t'(i));
        end
        return v;
    endfunction

    function automatic logic [7:0] stored_byte(cpu_addr_t a);
        if (written_bytes.exists(a)) begin
            return written_bytes[a];
        end
        return pattern_byte(a);
    endfunction

    // the lower byte of a beat has the lower address
    function automatic mem_beat_t line_beat(line_addr_t line, int k);
        return {stored_byte({line, offset_t'(2 * k + 1)}), stored_byte({line, offset_t'(2 * k)})};
    endfunction

    task automatic store_beat(line_addr_t line, int k, mem_beat_t beat);
        written_bytes[{line, offset_t'(2 * k)}] = beat[7:0];
        written_bytes[{line, offset_t'(2 * k + 1)}] = beat[15:8];
    endtask

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one LFSR step per bit taken, three bits give a delay of 1 to 8
    task automatic draw_delay(output int delay);
        logic [2:0] bits;
        bits = '0;
        for (int i = 0; i < 3; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            bits = {bits[1:0], lfsr_state[0]};
        end
        delay = int'(bits) + 1;
    endtask

    always @(posedge dump_cache) begin
        int d;
        if (reset) begin
            mem_phase <= mem_idle;
            mem_resp <= 1'b0;
        end else begin
            mem_resp <= 1'b0;
            case (mem_phase)
                mem_idle: begin
                    if (mem_cmd == write_line) begin
                        store_beat(mem_addr, 0, mem_wdata);
                        mem_line_q <= mem_addr;
                        mem_is_read <= 1'b0;
                        beat_count <= 1;
                        mem_phase <= mem_collect;
                    end else if (mem_cmd == read_line) begin
                        draw_delay(d);
                        mem_line_q <= mem_addr;
                        mem_is_read <= 1'b1;
                        delay_count <= d;
                        mem_phase <= mem_delay;
                    end
                end
                mem_collect: begin
                    store_beat(mem_line_q, beat_count, mem_wdata);
                    if (beat_count == `LINE_BEATS - 1) begin
                        draw_delay(d);
                        delay_count <= d;
                        mem_phase <= mem_delay;
                    end else begin
                        beat_count <= beat_count + 1;
                    end
                end
                mem_delay: begin
                    if (delay_count > 1) begin
                        delay_count <= delay_count - 1;
                    end else if (mem_is_read) begin
                        mem_resp <= 1'b1;
                        mem_rdata <= line_beat(mem_line_q, 0);
                        beat_count <= 1;
                        mem_phase <= mem_stream;
                    end else begin
                        mem_resp <= 1'b1;
                        mem_phase <= mem_idle;
                    end
                end
                default: begin
                    // fill beats go out back to back
                    mem_resp <= 1'b1;
                    mem_rdata <= line_beat(mem_line_q, beat_count);
                    if (beat_count == `LINE_BEATS - 1) begin
                        mem_phase <= mem_idle;
                    end else begin
                        beat_count <= beat_count + 1;
                    end
                end
            endcase
        end
    end

    task automatic add_entry(cpu_op_t op, cpu_addr_t addr, cpu_word_t wdata, cpu_word_t rdata,
                             logic [3:0] reads, logic [3:0] writes);
        stim_entry_t e;
        e = '{op: op, addr: addr, wdata: wdata, rdata: rdata, reads: reads, writes: writes};
        stimulus.push_back(e);
    endtask

    task automatic build_stimulus();
        add_entry(read32, t0_base, 32'h0, pattern_value(t0_base, 4), 4'd1, 4'd0);
        add_entry(read8, t0_base + 19'h5, 32'h0, 32'h11, 4'd0, 4'd0);
        add_entry(read16, t0_base + 19'ha, 32'h0, 32'h1f1e, 4'd0, 4'd0);
        add_entry(write8, t0_base + 19'h1, 32'ha5, 32'h0, 4'd0, 4'd0);
        add_entry(write16, t0_base + 19'h6, 32'hbeef, 32'h0, 4'd0, 4'd0);
        add_entry(write32, t0_base + 19'hc, 32'hdeadbeef, 32'h0, 4'd0, 4'd0);
        add_entry(read32, t0_base, 32'h0, 32'h1716a514, 4'd0, 4'd0);
        add_entry(read32, t0_base + 19'h4, 32'h0, 32'hbeef1110, 4'd0, 4'd0);
        add_entry(read16, t0_base + 19'he, 32'h0, 32'hdead, 4'd0, 4'd0);
        // two more tags in set 3 push the written line out
        add_entry(read32, t1_base + 19'h8, 32'h0, pattern_value(t1_base + 19'h8, 4), 4'd1, 4'd0);
        add_entry(read32, t2_base, 32'h0, pattern_value(t2_base, 4), 4'd1, 4'd1);
        add_entry(read32, t0_base, 32'h0, 32'h1716a514, 4'd1, 4'd0);
        add_entry(read32, t0_base + 19'hc, 32'h0, 32'hdeadbeef, 4'd0, 4'd0);
        add_entry(write32, t0_base + 19'h8, 32'h01234567, 32'h0, 4'd0, 4'd0);
        add_entry(invalidate, t0_base, 32'h0, 32'h0, 4'd0, 4'd1);
        add_entry(read32, t0_base + 19'h8, 32'h0, 32'h01234567, 4'd1, 4'd0);
        add_entry(read8, t0_base + 19'h6, 32'h0, 32'hef, 4'd0, 4'd0);
        add_entry(invalidate, t1_base, 32'h0, 32'h0, 4'd0, 4'd0);
        add_entry(invalidate, s7_base, 32'h0, 32'h0, 4'd0, 4'd0);
        add_entry(invalidate, t2_base, 32'h0, 32'h0, 4'd0, 4'd0);
        add_entry(read16, t2_base + 19'h2, 32'h0, pattern_value(t2_base + 19'h2, 2), 4'd1, 4'd0);
        add_entry(read8, s7_base + 19'hb, 32'h0, pattern_value(s7_base + 19'hb, 1), 4'd1, 4'd0);
        // a write miss fills the line before merging the byte
        add_entry(write8, s7_other + 19'h5, 32'h5a, 32'h0, 4'd1, 4'd0);
        add_entry(read16, s7_other + 19'h4, 32'h0,
                  pattern_value(s7_other + 19'h4, 1) | 32'h5a00, 4'd0, 4'd0);
    endtask

    task automatic wait_response(output logic seen);
        seen = 1'b0;
        for (int i = 0; i < resp_timeout && !seen; i++) begin
            @(posedge dump_cache);
            if (resp_valid) begin
                seen = 1'b1;
            end
        end
    endtask

    initial begin
        logic seen;
        build_stimulus();
        repeat (5) @(posedge dump_cache);
        reset <= 1'b0;
        for (int i = 0; i < stimulus.size() && timeouts == 0; i++) begin
            @(posedge dump_cache);
            cmd_valid <= 1'b1;
            cmd <= '{op: stimulus[i].op, addr: stimulus[i].addr, wdata: stimulus[i].wdata};
            exp_rdata <= stimulus[i].rdata;
            exp_reads <= stimulus[i].reads;
            exp_writes <= stimulus[i].writes;
            @(posedge dump_cache);
            cmd_valid <= 1'b0;
            wait_response(seen);
            if (!seen) begin
                $display("entry %0d got no response within %0d cycles", i, resp_timeout);
                timeouts++;
            end
        end
        repeat (2) @(posedge dump_cache);
        $display("checks %0d, errors %0d, timeouts %0d", check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* cache_system.f */
+incdir+design
design/cache_pkg.sv
design/cpu_request_port.sv
design/cache_storage.sv
design/cache_controller.sv
design/memory_line_port.sv
design/cache_top.sv
dv/cache_checker.sv
dv/cache_tb.sv

/* Makefile */
# Verilator build and run for the cache testbench

VERILATOR ?= verilator
TOP ?= cache_tb
FILELIST ?= cache_system.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert --timing -j 0

SOURCES := $(wildcard design/*.sv design/*.svh dv/*.sv)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# the run fails unless the pass line shows up in the output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)
